/* verilog/clock_pkg.sv */
`default_nettype none

package clock_pkg;

    // one decimal digit, 0..9
    typedef logic [3:0] bcd_digit_t;

    // most significant digit first, same order as the display
    typedef struct packed {
        bcd_digit_t min10;  // 0..5
        bcd_digit_t min1;   // 0..9
        bcd_digit_t sec10;  // 0..5
        bcd_digit_t sec1;   // 0..9
    } mmss_t;

    // 100 MHz board clock
    localparam int sec_div_default = 100_000_000;

    // 10 ms of stable level before a press counts
    localparam int debounce_cycles_default = 1_000_000;

endpackage

`default_nettype wire

/* verilog/panel_pkg.sv */
`default_nettype none

package panel_pkg;

    // which application owns the display and the function buttons
    typedef enum logic {
        app_watch     = 1'b0,
        app_stopwatch = 1'b1
    } app_mode_e;

    // function button pulses as seen by one application
    typedef struct packed {
        logic fn_a;  // set toggle / start-stop
        logic fn_b;  // sec increment / lap
        logic fn_c;  // min increment / clear
    } btn_pulses_t;

    localparam int n_buttons = 4;  // mode + three function buttons
    localparam int n_digits  = 4;

    // about 1 kHz per digit at 100 MHz
    localparam int scan_div_default = 100_000;

    // dp and all segments off, active low
    localparam logic [7:0] seg_blank = 8'hff;

endpackage

`default_nettype wire

/* verilog/button_cond.sv */
`timescale 1ns/1ps
`default_nettype none

module button_cond #(
    parameter int debounce_cycles = clock_pkg::debounce_cycles_default
) (
    input  logic                            clk,
    input  logic                            reset_p,
    input  logic [panel_pkg::n_buttons-1:0] btn,
    output logic [panel_pkg::n_buttons-1:0] press
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);

    logic [panel_pkg::n_buttons-1:0] sync_a;
    logic [panel_pkg::n_buttons-1:0] sync_b;
    logic [panel_pkg::n_buttons-1:0] level;    // debounced level
    logic [panel_pkg::n_buttons-1:0] level_d;  // for the edge detect
    logic [cnt_w-1:0]                stable_cnt [panel_pkg::n_buttons];

    // raw buttons are asynchronous to clk
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= btn;
            sync_b <= sync_a;
        end
    end

    // level follows the input once it has differed for debounce_cycles in a row
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            level   <= '0;
            level_d <= '0;
            for (int i = 0; i < panel_pkg::n_buttons; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            level_d <= level;
            for (int i = 0; i < panel_pkg::n_buttons; i++) begin
                if (sync_b[i] == level[i]) begin
                    stable_cnt[i] <= '0;  // bounce, start over
                end else if (stable_cnt[i] == cnt_w'(debounce_cycles - 1)) begin
                    level[i]      <= sync_b[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign press = level & ~level_d;  // rising edge only

endmodule

`default_nettype wire

/* verilog/time_base.sv */
`timescale 1ns/1ps
`default_nettype none

module time_base #(
    parameter int sec_div = 1_000
) (
    input  logic clk,
    input  logic reset_p,
    output logic sec_tick
);

    localparam int cnt_w = (sec_div > 1) ? $clog2(sec_div) : 1;

    logic [cnt_w-1:0] div_cnt;
    logic             wrap;

    assign wrap = (div_cnt == cnt_w'(sec_div - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt  <= '0;
            sec_tick <= 1'b0;
        end else begin
            sec_tick <= wrap;  // registered, first tick sec_div cycles after reset
            if (wrap) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mmss_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mmss_counter (
    input  logic             clk,
    input  logic             reset_p,
    input  logic             clear,
    input  logic             load,
    input  clock_pkg::mmss_t load_value,
    input  logic             inc_sec,
    input  logic             inc_min,
    output clock_pkg::mmss_t value
);

    logic [7:0] sec_next;  // {tens, ones} after one step
    logic [7:0] min_next;
    logic       sec_wrap;

    // one step of a 00..59 BCD pair
    function automatic logic [7:0] bcd60_inc(input clock_pkg::bcd_digit_t tens,
                                              input clock_pkg::bcd_digit_t ones);
        logic [7:0] nxt;
        if (ones != 4'd9) begin
            nxt = {tens, ones + 4'd1};
        end else if (tens != 4'd5) begin
            nxt = {tens + 4'd1, 4'd0};
        end else begin
            nxt = 8'h00;  // 59 -> 00
        end
        return nxt;
    endfunction

    assign sec_next = bcd60_inc(value.sec10, value.sec1);
    assign min_next = bcd60_inc(value.min10, value.min1);
    assign sec_wrap = (value.sec10 == 4'd5) && (value.sec1 == 4'd9);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end else if (inc_sec) begin
            {value.sec10, value.sec1} <= sec_next;
            if (sec_wrap) begin
                {value.min10, value.min1} <= min_next;  // carry into minutes
            end
        end else if (inc_min) begin
            {value.min10, value.min1} <= min_next;  // seconds untouched
        end
    end

endmodule

`default_nettype wire

/* verilog/watch_core.sv */
`timescale 1ns/1ps
`default_nettype none

module watch_core (
    input  logic                   clk,
    input  logic                   reset_p,
    input  logic                   sec_tick,
    input  panel_pkg::btn_pulses_t btn,
    output clock_pkg::mmss_t       value,
    output logic                   set_mode
);

    clock_pkg::mmss_t run_value;
    clock_pkg::mmss_t set_value;
    logic             enter_set;
    logic             leave_set;

    assign enter_set = btn.fn_a & ~set_mode;
    assign leave_set = btn.fn_a & set_mode;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_mode <= 1'b0;
        end else if (btn.fn_a) begin
            set_mode <= ~set_mode;
        end
    end

    // keeps ticking while the set copy is edited
    mmss_counter run_cnt (
        .clk        (clk),
        .reset_p    (reset_p),
        .clear      (1'b0),
        .load       (leave_set),
        .load_value (set_value),
        .inc_sec    (sec_tick),
        .inc_min    (1'b0),
        .value      (run_value)
    );

    // snapshot of the running time, raised by the buttons
    mmss_counter set_cnt (
        .clk        (clk),
        .reset_p    (reset_p),
        .clear      (1'b0),
        .load       (enter_set),
        .load_value (run_value),
        .inc_sec    (btn.fn_b & set_mode),
        .inc_min    (btn.fn_c & set_mode),
        .value      (set_value)
    );

    assign value = set_mode ? set_value : run_value;

endmodule

`default_nettype wire

/* verilog/stopwatch_core.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_core (
    input  logic                   clk,
    input  logic                   reset_p,
    input  logic                   sec_tick,
    input  panel_pkg::btn_pulses_t btn,
    output clock_pkg::mmss_t       value,
    output logic                   running,
    output logic                   lap_shown
);

    clock_pkg::mmss_t live_value;
    clock_pkg::mmss_t lap_value;

    // clear wins over start-stop and lap
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running   <= 1'b0;
            lap_shown <= 1'b0;
        end else if (btn.fn_c) begin
            running   <= 1'b0;
            lap_shown <= 1'b0;
        end else begin
            if (btn.fn_a) begin
                running <= ~running;
            end
            if (btn.fn_b) begin
                lap_shown <= ~lap_shown;
            end
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            lap_value <= '0;
        end else if (btn.fn_c) begin
            lap_value <= '0;
        end else if (btn.fn_b) begin
            lap_value <= live_value;  // capture on every lap press
        end
    end

    // ticks only while running
    mmss_counter live_cnt (
        .clk        (clk),
        .reset_p    (reset_p),
        .clear      (btn.fn_c),
        .load       (1'b0),
        .load_value ('0),
        .inc_sec    (sec_tick & running),
        .inc_min    (1'b0),
        .value      (live_value)
    );

    assign value = lap_shown ? lap_value : live_value;

endmodule

`default_nettype wire

/* verilog/panel_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl (
    input  logic                            clk,
    input  logic                            reset_p,
    input  logic [panel_pkg::n_buttons-1:0] press,
    input  clock_pkg::mmss_t                watch_value,
    input  clock_pkg::mmss_t                sw_value,
    output panel_pkg::btn_pulses_t          watch_btn,
    output panel_pkg::btn_pulses_t          sw_btn,
    output clock_pkg::mmss_t                disp_value,
    output panel_pkg::app_mode_e            mode
);

    panel_pkg::btn_pulses_t fn;

    // press[0] is the mode button
    assign fn.fn_a = press[1];
    assign fn.fn_b = press[2];
    assign fn.fn_c = press[3];

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= panel_pkg::app_watch;
        end else if (press[0]) begin
            mode <= (mode == panel_pkg::app_watch) ? panel_pkg::app_stopwatch
                                                   : panel_pkg::app_watch;
        end
    end

    // idle application sees no pulses
    always_comb begin
        watch_btn = '0;
        sw_btn    = '0;
        if (mode == panel_pkg::app_watch) begin
            watch_btn  = fn;
            disp_value = watch_value;
        end else begin
            sw_btn     = fn;
            disp_value = sw_value;
        end
    end

endmodule

`default_nettype wire

/* verilog/fnd_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module fnd_scan #(
    parameter int scan_div = panel_pkg::scan_div_default
) (
    input  logic                           clk,
    input  logic                           reset_p,
    input  clock_pkg::mmss_t               value,
    output logic [panel_pkg::n_digits-1:0] com,
    output logic [7:0]                     seg_7
);

    localparam int cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [cnt_w-1:0]                        scan_cnt;
    logic [$clog2(panel_pkg::n_digits)-1:0]  digit_idx;  // 0 is the rightmost digit
    clock_pkg::bcd_digit_t                   digit;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == cnt_w'(scan_div - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;  // wraps after the last digit
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        com            = '1;
        com[digit_idx] = 1'b0;  // active low
    end

    always_comb begin
        case (digit_idx)
            2'd0:    digit = value.sec1;
            2'd1:    digit = value.sec10;
            2'd2:    digit = value.min1;
            default: digit = value.min10;
        endcase
    end

    // {dp, g..a}, active low
    always_comb begin
        case (digit)
            4'd0:    seg_7 = 8'hc0;
            4'd1:    seg_7 = 8'hf9;
            4'd2:    seg_7 = 8'ha4;
            4'd3:    seg_7 = 8'hb0;
            4'd4:    seg_7 = 8'h99;
            4'd5:    seg_7 = 8'h92;
            4'd6:    seg_7 = 8'h82;
            4'd7:    seg_7 = 8'hf8;
            4'd8:    seg_7 = 8'h80;
            4'd9:    seg_7 = 8'h90;
            default: seg_7 = panel_pkg::seg_blank;  // not a BCD digit
        endcase
    end

endmodule

`default_nettype wire

/* verilog/clock_panel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_panel_top #(
    parameter int sec_div         = clock_pkg::sec_div_default,
    parameter int scan_div        = panel_pkg::scan_div_default,
    parameter int debounce_cycles = clock_pkg::debounce_cycles_default
) (
    input  logic                            clk,
    input  logic                            reset_p,
    input  logic [panel_pkg::n_buttons-1:0] btn,
    output logic [panel_pkg::n_digits-1:0]  com,
    output logic [7:0]                      seg_7,
    output logic                            led_mode,
    output logic                            led_set,
    output logic                            led_run,
    output logic                            led_lap
);

    logic [panel_pkg::n_buttons-1:0] press;
    logic                            sec_tick;
    panel_pkg::btn_pulses_t          watch_btn;
    panel_pkg::btn_pulses_t          sw_btn;
    clock_pkg::mmss_t                watch_value;
    clock_pkg::mmss_t                sw_value;
    clock_pkg::mmss_t                disp_value;
    panel_pkg::app_mode_e            mode;

    assign led_mode = (mode == panel_pkg::app_stopwatch);

    button_cond #(.debounce_cycles(debounce_cycles)) u_buttons (
        .clk(clk), .reset_p(reset_p), .btn(btn), .press(press)
    );

    time_base #(.sec_div(sec_div)) u_time_base (
        .clk(clk), .reset_p(reset_p), .sec_tick(sec_tick)
    );

    panel_ctrl u_panel (
        .clk(clk), .reset_p(reset_p), .press(press),
        .watch_value(watch_value), .sw_value(sw_value),
        .watch_btn(watch_btn), .sw_btn(sw_btn),
        .disp_value(disp_value), .mode(mode)
    );

    watch_core u_watch (
        .clk(clk), .reset_p(reset_p), .sec_tick(sec_tick), .btn(watch_btn),
        .value(watch_value), .set_mode(led_set)
    );

    stopwatch_core u_stopwatch (
        .clk(clk), .reset_p(reset_p), .sec_tick(sec_tick), .btn(sw_btn),
        .value(sw_value), .running(led_run), .lap_shown(led_lap)
    );

    fnd_scan #(.scan_div(scan_div)) u_fnd (
        .clk(clk), .reset_p(reset_p), .value(disp_value), .com(com), .seg_7(seg_7)
    );

endmodule

`default_nettype wire

/* bench/clock_panel_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_panel_checker (
    input logic                            clk,
    input logic                            reset_p,
    input logic [panel_pkg::n_digits-1:0]  com,
    input logic [panel_pkg::n_buttons-1:0] press,
    input panel_pkg::btn_pulses_t          sw_btn,
    input logic                            led_run
);

    // exactly one digit lit at a time
    com_one_hot: assert property (@(posedge clk) disable iff (reset_p) $onehot(~com))
        else $error("com is not one-hot low: %b", com);

    press_single: assert property (@(posedge clk) disable iff (reset_p)
        (press & $past(press)) == '0)  // no pulse longer than a cycle
        else $error("press pulse held for two cycles: %b", press);

    // clear always stops the stopwatch
    clear_stops: assert property (@(posedge clk) disable iff (reset_p) sw_btn.fn_c |=> !led_run)
        else $error("stopwatch still running after a clear pulse");

endmodule

bind clock_panel_top clock_panel_checker u_checker (
    .clk(clk), .reset_p(reset_p), .com(com), .press(press),
    .sw_btn(sw_btn), .led_run(led_run)
);

`default_nettype wire

/* bench/clock_panel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_panel_tb;

    localparam int sec_div  = 200;
    localparam int scan_div = 4;

    // active-high g..a patterns with digit 9 in the top bits
    localparam logic [69:0] glyphs = {7'h6f, 7'h7f, 7'h07, 7'h7d, 7'h6d,
                                      7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f};

    logic       clk;
    logic       reset_p;
    logic [3:0] btn;
    logic [3:0] com;
    logic [7:0] seg_7;
    logic       led_mode;
    logic       led_set;
    logic       led_run;
    logic       led_lap;

    integer           seed;
    int               errors = 0;
    int               cycles = 0;
    int               timeout_cycles;
    bit               plan_ready = 1'b0;
    int               n_sec;
    int               n_min;
    int               k;
    int               n_route;
    int               t0;
    clock_pkg::mmss_t base;
    clock_pkg::mmss_t set_val;
    clock_pkg::mmss_t shown;
    clock_pkg::mmss_t frozen;

    clock_panel_top #(.sec_div(sec_div), .scan_div(scan_div), .debounce_cycles(3)) DUT (
        .clk(clk), .reset_p(reset_p), .btn(btn), .com(com), .seg_7(seg_7),
        .led_mode(led_mode), .led_set(led_set), .led_run(led_run), .led_lap(led_lap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset_p) begin
            cycles <= cycles + 1;  // elapsed time for the watch model
        end
    end

    function automatic int to_secs(input clock_pkg::mmss_t v);
        return (int'(v.min10) * 10 + int'(v.min1)) * 60
               + int'(v.sec10) * 10 + int'(v.sec1);
    endfunction

    function automatic clock_pkg::mmss_t from_secs(input int s);
        clock_pkg::mmss_t v;
        v.min10 = 4'(s / 600);
        v.min1  = 4'((s / 60) % 10);
        v.sec10 = 4'((s % 60) / 10);
        v.sec1  = 4'(s % 10);
        return v;
    endfunction

    // seconds carry into minutes and 59:59 wraps to 00:00
    function automatic clock_pkg::mmss_t add_secs(input clock_pkg::mmss_t v, input int n);
        return from_secs(((to_secs(v) + n) % 3600 + 3600) % 3600);
    endfunction

    // minute steps leave the seconds alone
    function automatic clock_pkg::mmss_t add_mins(input clock_pkg::mmss_t v, input int n);
        return from_secs(((to_secs(v) / 60 + n) % 60) * 60 + to_secs(v) % 60);
    endfunction

    function automatic int seg_to_digit(input logic [7:0] seg);
        int d;
        d = -1;
        for (int g = 0; g < 10; g++) begin
            if (seg[7] && ~seg[6:0] == glyphs[g*7 +: 7]) d = g;  // dp must stay dark
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_within(input string name, input clock_pkg::mmss_t actual,
                                 input clock_pkg::mmss_t expected, input int lo, input int hi);
        int diff;
        diff = (to_secs(actual) - to_secs(expected) + 5400) % 3600 - 1800;
        if (diff < lo) begin
            diff = lo;
        end else if (diff > hi) begin
            diff = hi;
        end
        check_value(name, add_secs(expected, diff), actual);  // nearest allowed reading
    endtask

    task automatic press_button(input int idx);
        btn[idx] = 1'b1;
        repeat (10) @(negedge clk);
        btn[idx] = 1'b0;
        repeat (10) @(negedge clk);
    endtask

    // reads all four digits until two full scans agree
    task automatic read_display(output clock_pkg::mmss_t v);
        logic [15:0] now;
        logic [15:0] prev;
        logic [3:0]  want;
        int          d;
        int          waited;
        prev = 16'hffff;
        now  = 16'hfffe;
        for (int pass = 0; pass < 4 && now != prev; pass++) begin
            prev = now;
            for (int i = 0; i < 4; i++) begin
                want   = ~(4'b0001 << i);
                waited = 0;
                while (com !== want && waited < 8 * scan_div) begin
                    @(negedge clk);
                    waited++;
                end
                d = seg_to_digit(seg_7);
                if (com !== want || d < 0) begin
                    $display("%0t: digit %0d of the display could not be read", $time, i);
                    errors++;
                end
                now[i*4 +: 4] = 4'(d);
            end
        end
        v = now;
    endtask

    initial begin
        wait (plan_ready);
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed    = 32'h6a6a;
        btn     = '0;
        reset_p = 1'b1;
        n_sec   = 1 + {$random(seed)} % 12;
        n_min   = 1 + {$random(seed)} % 8;
        k       = 2 + {$random(seed)} % 3;
        n_route = 1 + {$random(seed)} % 3;
        timeout_cycles = (11 + n_sec + n_min + 2 * n_route) * 30 + 40 * sec_div;
        plan_ready = 1'b1;
        repeat (4) @(negedge clk);
        check_value("com", 16'b1110, 16'(com));
        reset_p = 1'b0;
        check_value("{led_mode,led_set,led_run,led_lap}", 16'd0,
                    16'({led_mode, led_set, led_run, led_lap}));
        read_display(shown);
        check_value("display", 16'd0, shown);

        press_button(1);  // enter set mode
        check_value("led_set", 16'd1, 16'(led_set));
        read_display(base);
        repeat (n_sec) press_button(2);
        repeat (n_min) press_button(3);
        set_val = add_mins(add_secs(base, n_sec), n_min);
        read_display(shown);
        check_value("display", set_val, shown);
        repeat (3 * sec_div) @(negedge clk);
        read_display(shown);
        check_value("display", set_val, shown);
        check_value("led_set", 16'd1, 16'(led_set));

        t0 = cycles;
        press_button(1);  // back to the running watch
        check_value("led_set", 16'd0, 16'(led_set));
        read_display(shown);
        expect_within("watch after set", shown, set_val, 0, 2);

        press_button(0);
        check_value("led_mode", 16'd1, 16'(led_mode));
        press_button(3);
        read_display(shown);
        check_value("display", 16'd0, shown);
        repeat (2 * sec_div) @(negedge clk);
        read_display(shown);
        check_value("display", 16'd0, shown);
        press_button(1);
        check_value("led_run", 16'd1, 16'(led_run));
        repeat (k * sec_div) @(negedge clk);
        press_button(1);
        check_value("led_run", 16'd0, 16'(led_run));
        read_display(frozen);
        expect_within("stopwatch after stop", frozen, from_secs(k), -1, 1);
        repeat (sec_div) @(negedge clk);
        read_display(shown);
        check_value("display", frozen, shown);

        press_button(1);
        repeat (sec_div) @(negedge clk);
        press_button(2);  // lap
        check_value("led_lap", 16'd1, 16'(led_lap));
        read_display(frozen);
        repeat (2 * sec_div) @(negedge clk);
        read_display(shown);
        check_value("display", frozen, shown);
        press_button(2);
        check_value("led_lap", 16'd0, 16'(led_lap));
        read_display(shown);
        expect_within("stopwatch after lap", shown, frozen, 0, 60);

        for (int i = 0; i < n_route; i++) begin
            press_button(2);
            press_button(3);
        end
        check_value("{led_set,led_run,led_lap}", 16'd0, 16'({led_set, led_run, led_lap}));
        press_button(0);
        check_value("{led_mode,led_set}", 16'd0, 16'({led_mode, led_set}));
        read_display(shown);
        expect_within("watch after routing", shown,
                      add_secs(set_val, (cycles - t0) / sec_div), -1, 1);

        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/clock_pkg.sv
verilog/panel_pkg.sv
verilog/button_cond.sv
verilog/time_base.sv
verilog/mmss_counter.sv
verilog/watch_core.sv
verilog/stopwatch_core.sv
verilog/panel_ctrl.sv
verilog/fnd_scan.sv
verilog/clock_panel_top.sv
bench/clock_panel_checker.sv
bench/clock_panel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the clock panel testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module clock_panel_tb -Mdir obj_dir \
    || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vclock_panel_tb 2>&1)"
echo "$out"
echo "$out" | grep -q "^Simulation completed successfully$" && exit 0 || exit 1
